// File: Makefile
SOURCES = sources.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

# the simulator binary is rebuilt only when a source or the file list changes
obj_dir/Vscheduler_tb: $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module scheduler_tb -f sources.f

sim.log: obj_dir/Vscheduler_tb
	./obj_dir/Vscheduler_tb > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: sources.f
+incdir+verilog
+incdir+verification
verilog/scheduler_pkg.sv
verilog/grant_planner.sv
verilog/slot_allocator.sv
verilog/age_matrix.sv
verilog/scheduler_top.sv
verification/scheduler_tb.sv

// File: verification/scheduler_vectors.svh
`ifndef SCHEDULER_VECTORS_SVH
`define SCHEDULER_VECTORS_SVH

localparam int DIRECTED_ROWS = 16;

// *********************************************************************
// directed rows, one per cycle
// *********************************************************************

// each row holds the occupancy, ready count, flush flag, enter mask, set indexes
// with two bits per slot and slot 0 lowest, used count, matrix check kind, matrix
// slot and matrix value.
// the matrix column describes the order after the row's own entries are applied.
task automatic load_directed_rows();
	// all free, three ready. Slots 0 to 2 enter in order.
	add_row(8'h00, 2'd3, 1'b0, 8'h07, 16'h0024, 2'd3, MAT_NONE, 3'd0, 8'h00);
	// slots 0, 1 and 3 busy. One goes low, the other two spill high.
	add_row(8'h0b, 2'd3, 1'b0, 8'h34, 16'h0900, 2'd3, MAT_NONE, 3'd0, 8'h00);
	// flushes hold everything back.
	add_row(8'h00, 2'd3, 1'b1, 8'h00, 16'h0000, 2'd0, MAT_NONE, 3'd0, 8'h00);
	add_row(8'hf0, 2'd2, 1'b1, 8'h00, 16'h0000, 2'd0, MAT_NONE, 3'd0, 8'h00);
	// slot 5 alone becomes the youngest.
	add_row(8'hdf, 2'd1, 1'b0, 8'h20, 16'h0000, 2'd1, MAT_ROW, 3'd5, 8'hdf);
	add_row(8'hff, 2'd0, 1'b0, 8'h00, 16'h0000, 2'd0, MAT_COL, 3'd5, 8'h00);
	// slots 1 and 6 together, where 6 ends up after 1.
	add_row(8'hbd, 2'd2, 1'b0, 8'h42, 16'h1000, 2'd2, MAT_ROW, 3'd6, 8'hbf);
	add_row(8'hff, 2'd3, 1'b0, 8'h00, 16'h0000, 2'd0, MAT_ROW, 3'd1, 8'hbd);
	// low group full, so the high group takes the whole bundle.
	add_row(8'h0f, 2'd3, 1'b0, 8'h70, 16'h2400, 2'd3, MAT_ROW, 3'd7, 8'h08);
	add_row(8'h55, 2'd2, 1'b0, 8'h0a, 16'h0040, 2'd2, MAT_ROW, 3'd0, 8'h80);
	add_row(8'h3c, 2'd3, 1'b0, 8'h43, 16'h2004, 2'd3, MAT_COL, 3'd3, 8'h43);
	add_row(8'h00, 2'd0, 1'b0, 8'h00, 16'h0000, 2'd0, MAT_ROW, 3'd4, 8'h84);
	add_row(8'h00, 2'd2, 1'b0, 8'h03, 16'h0004, 2'd2, MAT_ROW, 3'd2, 8'h80);
	// a single free slot caps the bundle at one.
	add_row(8'hfe, 2'd3, 1'b0, 8'h01, 16'h0000, 2'd1, MAT_ROW, 3'd0, 8'hfe);
	add_row(8'h00, 2'd1, 1'b1, 8'h00, 16'h0000, 2'd0, MAT_ROW, 3'd6, 8'hbc);
	add_row(8'h77, 2'd3, 1'b0, 8'h88, 16'h4000, 2'd2, MAT_ROW, 3'd3, 8'h77);
endtask

`endif

// File: verification/scheduler_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scheduler_config.svh"

module scheduler_tb
	import scheduler_pkg::*;
();

	localparam int SLOTS = `SCHED_SLOT_COUNT;
	localparam int GROUP = `SCHED_GROUP_SIZE;
	localparam int SLOT_BITS = $clog2(`SCHED_SLOT_COUNT);
	localparam int INDEX_BITS = `SCHED_SLOT_COUNT * `SCHED_INDEX_WIDTH;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_ROWS = 200;
	localparam logic [31:0] RANDOM_SEED = 32'h6da1da6b;
	localparam logic [1:0] MAT_NONE = 2'd0;
	localparam logic [1:0] MAT_ROW = 2'd1;
	localparam logic [1:0] MAT_COL = 2'd2;

	typedef struct packed {
		slot_mask_t occ;
		issue_count_t ready;
		logic flush;
		slot_mask_t enter;
		logic [INDEX_BITS-1:0] set_idx;
		issue_count_t used;
		logic [1:0] mat_kind;
		logic [SLOT_BITS-1:0] mat_slot;
		age_row_t mat_value;
	} vector_t;

	logic main_clk;
	logic rst_n;
	slot_mask_t slot_valid_next;
	issue_count_t ready_count_next;
	logic flush_next;
	slot_mask_t enter_mask;
	set_index_t set_index [0:`SCHED_SLOT_COUNT-1];
	issue_count_t used_count;
	age_row_t after_matrix [0:`SCHED_SLOT_COUNT-1];

	vector_t rows [$];
	int check_count = 0;
	int error_count = 0;
	int mark_checks = 0;
	int mark_errors = 0;
	int cycle_count = 0;

	scheduler_top scheduler_top_i (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.slot_valid_next(slot_valid_next),
		.ready_count_next(ready_count_next),
		.flush_next(flush_next),
		.enter_mask(enter_mask),
		.set_index(set_index),
		.used_count(used_count),
		.after_matrix(after_matrix)
	);

	function automatic void add_row(
		input slot_mask_t occ,
		input issue_count_t ready,
		input logic flush,
		input slot_mask_t enter,
		input logic [INDEX_BITS-1:0] set_idx,
		input issue_count_t used,
		input logic [1:0] mat_kind,
		input logic [SLOT_BITS-1:0] mat_slot,
		input age_row_t mat_value
	);
		rows.push_back({occ, ready, flush, enter, set_idx, used, mat_kind, mat_slot, mat_value});
	endfunction

	`include "scheduler_vectors.svh"

	// each test gets its rows plus two drain cycles, and reset gets a few more.
	localparam int MAX_CYCLES = RESET_CYCLES + 3 + DIRECTED_ROWS + RANDOM_ROWS + 4 + 32;

	// *********************************************************************
	// reference allocation
	// *********************************************************************

	// free room per group is clipped to one bundle. The low group is filled
	// first and the rest of the ready count spills into the high group.
	// ranks in the high group start where the low group stopped.
	function automatic void expect_allocation(
		input slot_mask_t occ,
		input issue_count_t ready,
		input logic flush,
		output slot_mask_t enter,
		output logic [INDEX_BITS-1:0] set_idx,
		output issue_count_t used
	);
		int room [2];
		int quota [2];
		int taken [2];
		int g;
		for (int k = 0; k < 2; k++) begin
			room[k] = 0;
			taken[k] = 0;
		end
		for (int s = 0; s < SLOTS; s++) begin
			if (!occ[s]) begin
				room[s / GROUP]++;
			end
		end
		for (int k = 0; k < 2; k++) begin
			if (room[k] > `SCHED_MAX_ISSUE) begin
				room[k] = `SCHED_MAX_ISSUE;
			end
		end
		quota[0] = (int'(ready) < room[0]) ? int'(ready) : room[0];
		quota[1] = ((int'(ready) - quota[0]) < room[1]) ? (int'(ready) - quota[0]) : room[1];
		if (flush) begin
			quota[0] = 0;
			quota[1] = 0;
		end
		enter = '0;
		set_idx = '0;
		for (int s = 0; s < SLOTS; s++) begin
			g = s / GROUP;
			if (!occ[s] && taken[g] < quota[g]) begin
				enter[s] = 1'b1;
				set_idx[s*`SCHED_INDEX_WIDTH +: `SCHED_INDEX_WIDTH] =
					set_index_t'(((g == 0) ? 0 : quota[0]) + taken[g]);
				taken[g]++;
			end
		end
		used = issue_count_t'(quota[0] + quota[1]);
	endfunction

	function automatic void build_random_rows(input int count);
		vector_t v;
		for (int n = 0; n < count; n++) begin
			v = '0;
			v.occ = slot_mask_t'($urandom);
			v.ready = issue_count_t'($urandom_range(3, 0));
			v.flush = ($urandom_range(7, 0) == 0);
			expect_allocation(v.occ, v.ready, v.flush, v.enter, v.set_idx, v.used);
			v.mat_kind = MAT_NONE;
			rows.push_back(v);
		end
	endfunction

	// *********************************************************************
	// checks
	// *********************************************************************

	task automatic compare_value(
		input string what,
		input logic [15:0] got,
		input logic [15:0] expected
	);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic check_outputs(input int r);
		vector_t v;
		v = rows[r];
		compare_value("enter_mask", 16'(enter_mask), 16'(v.enter));
		compare_value("used_count", 16'(used_count), 16'(v.used));
		for (int s = 0; s < SLOTS; s++) begin
			compare_value($sformatf("set_index[%0d]", s), 16'(set_index[s]),
				16'(v.set_idx[s*`SCHED_INDEX_WIDTH +: `SCHED_INDEX_WIDTH]));
		end
	endtask

	task automatic check_matrix(input int r);
		vector_t v;
		age_row_t got;
		v = rows[r];
		if (v.mat_kind == MAT_ROW) begin
			compare_value($sformatf("after_matrix[%0d]", v.mat_slot),
				16'(after_matrix[v.mat_slot]), 16'(v.mat_value));
		end else if (v.mat_kind == MAT_COL) begin
			for (int i = 0; i < SLOTS; i++) begin
				got[i] = after_matrix[i][v.mat_slot];
			end
			compare_value($sformatf("after_matrix column %0d", v.mat_slot),
				16'(got), 16'(v.mat_value));
		end
	endtask

	// right after reset the lower slot of every pair is the older one.
	task automatic check_reset_state();
		age_row_t expected;
		compare_value("enter_mask", 16'(enter_mask), 16'h0000);
		compare_value("used_count", 16'(used_count), 16'h0000);
		for (int i = 0; i < SLOTS; i++) begin
			for (int j = 0; j < SLOTS; j++) begin
				expected[j] = (j < i);
			end
			compare_value($sformatf("after_matrix[%0d]", i), 16'(after_matrix[i]),
				16'(expected));
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, check_count - mark_checks,
			error_count - mark_errors);
		mark_checks = check_count;
		mark_errors = error_count;
	endtask

	// *********************************************************************
	// stimulus
	// *********************************************************************

	task automatic drive_idle();
		slot_valid_next <= '1;
		ready_count_next <= '0;
		flush_next <= 1'b0;
	endtask

	// inputs go in on a rising edge and are sampled on the next one. The
	// allocation is read at the falling edge after that, and the matrix a
	// cycle later still.
	task automatic apply_rows(input int first, input int count);
		for (int c = 0; c < count + 2; c++) begin
			@(posedge main_clk);
			if (c < count) begin
				slot_valid_next <= rows[first + c].occ;
				ready_count_next <= rows[first + c].ready;
				flush_next <= rows[first + c].flush;
			end else begin
				drive_idle();
			end
			@(negedge main_clk);
			if (c >= 1 && c <= count) begin
				check_outputs(first + c - 1);
			end
			if (c >= 2) begin
				check_matrix(first + c - 2);
			end
		end
	endtask

	initial begin
		main_clk = 1'b0;
		forever #4 main_clk = ~main_clk;
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge main_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rst_n <= 1'b0;
		drive_idle();
		void'($urandom(RANDOM_SEED));
		load_directed_rows();
		build_random_rows(RANDOM_ROWS);
		repeat (RESET_CYCLES) @(posedge main_clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge main_clk);
		@(negedge main_clk);
		check_reset_state();
		report_test("reset_state");
		apply_rows(0, DIRECTED_ROWS);
		report_test("directed_table");
		apply_rows(DIRECTED_ROWS, RANDOM_ROWS);
		report_test("random_tail");
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/age_matrix.sv
`timescale 1ns/1ps
`default_nettype none

`include "scheduler_config.svh"

module age_matrix
	import scheduler_pkg::*;
(
	input wire main_clk,
	input wire rst_n,
	input wire slot_mask_t enter_mask,
	output age_row_t after_matrix [0:`SCHED_SLOT_COUNT-1]
);

	typedef age_row_t [`SCHED_SLOT_COUNT-1:0] age_table_t;

	// *******************************************************************
	// matrix helpers
	// *******************************************************************

	// only the upper half of a table is trusted. The lower half is taken
	// as its inverse and the diagonal is cleared.
	function automatic age_table_t normalize(input age_table_t raw);
		age_table_t fixed;
		for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
			for (int j = 0; j < `SCHED_SLOT_COUNT; j++) begin
				if (i == j) begin
					fixed[i][j] = 1'b0;
				end else if (j > i) begin
					fixed[i][j] = raw[i][j];
				end else begin
					fixed[i][j] = !raw[j][i];
				end
			end
		end
		return fixed;
	endfunction

	// after reset a higher slot counts as younger than a lower one.
	function automatic age_table_t initial_order();
		age_table_t m;
		for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
			for (int j = 0; j < `SCHED_SLOT_COUNT; j++) begin
				m[i][j] = (j < i);
			end
		end
		return m;
	endfunction

	function automatic logic is_consistent(input age_table_t m);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
			if (m[i][i]) begin
				ok = 1'b0;
			end
			for (int j = i + 1; j < `SCHED_SLOT_COUNT; j++) begin
				if (m[i][j] == m[j][i]) begin
					ok = 1'b0;
				end
			end
		end
		return ok;
	endfunction

	// *******************************************************************
	// update
	// *******************************************************************

	age_table_t stored;
	age_table_t view;
	age_table_t entered;
	age_table_t next_matrix;

	assign view = normalize(stored);

	// entries are applied in slot order. An entering slot becomes after
	// every other slot, then its column is cleared so that no one is
	// after it. When two slots enter together the later step wins, so
	// the higher slot ends up the younger one.
	always_comb begin
		entered = view;
		for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
			if (enter_mask[i]) begin
				entered[i] = '1;
				for (int r = 0; r < `SCHED_SLOT_COUNT; r++) begin
					entered[r][i] = 1'b0;
				end
			end
		end
	end

	assign next_matrix = normalize(entered);

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			stored <= initial_order();
		end else begin
			stored <= next_matrix;
		end
	end

	always_comb begin
		for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
			after_matrix[i] = view[i];
		end
	end

	// the row and column writes alone already keep the order strict.
	a_order_consistent: assert property (
		@(posedge main_clk) disable iff (!rst_n)
		is_consistent(entered)
	);

endmodule

`default_nettype wire

// File: verilog/grant_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "scheduler_config.svh"

module grant_planner
	import scheduler_pkg::*;
(
	input wire main_clk,
	input wire rst_n,
	input wire slot_mask_t slot_valid_next,
	input wire issue_count_t ready_count_next,
	input wire flush_next,
	output slot_mask_t free_mask,
	output issue_count_t count_lo,
	output issue_count_t count_hi
);

	// *******************************************************************
	// free slot counting
	// *******************************************************************

	// counts the free slots of one group and clips the result to the
	// issue width, since no group can ever take more than that.
	function automatic issue_count_t sat_free_count(
		input logic [`SCHED_GROUP_SIZE-1:0] bits
	);
		int unsigned total;
		total = 0;
		for (int i = 0; i < `SCHED_GROUP_SIZE; i++) begin
			total = total + int'(bits[i]);
		end
		if (total > `SCHED_MAX_ISSUE) begin
			total = `SCHED_MAX_ISSUE;
		end
		return issue_count_t'(total);
	endfunction

	slot_mask_t free_next;
	issue_count_t free_lo;
	issue_count_t free_hi;
	issue_count_t grant_lo;
	issue_count_t grant_hi;
	issue_count_t remain;

	assign free_next = ~slot_valid_next;
	assign free_lo = sat_free_count(free_next[`SCHED_GROUP_SIZE-1:0]);
	assign free_hi = sat_free_count(free_next[`SCHED_SLOT_COUNT-1:`SCHED_GROUP_SIZE]);

	// *******************************************************************
	// ready count split
	// *******************************************************************

	// the low group is served first. Whatever it cannot absorb spills
	// over to the high group, clipped again by the high group's room.
	always_comb begin
		grant_lo = (ready_count_next < free_lo) ? ready_count_next : free_lo;
		remain = ready_count_next - grant_lo;
		grant_hi = (remain < free_hi) ? remain : free_hi;
		if (flush_next) begin
			grant_lo = '0;
			grant_hi = '0;
		end
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			count_lo <= '0;
			count_hi <= '0;
		end else begin
			count_lo <= grant_lo;
			count_hi <= grant_hi;
		end
	end

	// stage two sees the free slots of the same cycle as the counts.
	always_ff @(posedge main_clk) begin
		free_mask <= free_next;
	end

	// the two groups together never admit more than one issue bundle.
	a_split_within_issue: assert property (
		@(posedge main_clk) disable iff (!rst_n)
		({1'b0, count_lo} + {1'b0, count_hi}) <= `SCHED_MAX_ISSUE
	);

endmodule

`default_nettype wire

// File: verilog/scheduler_config.svh
`ifndef SCHEDULER_CONFIG_SVH
`define SCHEDULER_CONFIG_SVH

// window geometry. The window is split into equal groups of slots.
`define SCHED_SLOT_COUNT 8
`define SCHED_GROUP_SIZE 4

// at most this many instructions may enter the window in one cycle.
`define SCHED_MAX_ISSUE 3

// width of every count and set index, wide enough for SCHED_MAX_ISSUE.
`define SCHED_INDEX_WIDTH 2

`endif

// File: verilog/scheduler_pkg.sv
`default_nettype none

`include "scheduler_config.svh"

package scheduler_pkg;

	// one bit per window slot, used for occupancy, free and enter masks.
	typedef logic [`SCHED_SLOT_COUNT-1:0] slot_mask_t;

	// a count of instructions, zero up to the maximum issue width.
	typedef logic [`SCHED_INDEX_WIDTH-1:0] issue_count_t;

	// rank of an entering instruction among those entering in the same cycle.
	typedef logic [`SCHED_INDEX_WIDTH-1:0] set_index_t;

	// one row of the age matrix.
	// bit j of row i set means slot i entered after slot j.
	typedef logic [`SCHED_SLOT_COUNT-1:0] age_row_t;

endpackage

`default_nettype wire

// File: verilog/scheduler_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "scheduler_config.svh"

module scheduler_top
	import scheduler_pkg::*;
(
	input wire main_clk,
	input wire rst_n,
	input wire slot_mask_t slot_valid_next,
	input wire issue_count_t ready_count_next,
	input wire flush_next,
	output slot_mask_t enter_mask,
	output set_index_t set_index [0:`SCHED_SLOT_COUNT-1],
	output issue_count_t used_count,
	output age_row_t after_matrix [0:`SCHED_SLOT_COUNT-1]
);

	// registered plan from stage one.
	slot_mask_t free_mask;
	issue_count_t count_lo;
	issue_count_t count_hi;

	grant_planner grant_planner_i (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.slot_valid_next(slot_valid_next),
		.ready_count_next(ready_count_next),
		.flush_next(flush_next),
		.free_mask(free_mask),
		.count_lo(count_lo),
		.count_hi(count_hi)
	);

	slot_allocator slot_allocator_i (
		.free_mask(free_mask),
		.count_lo(count_lo),
		.count_hi(count_hi),
		.enter_mask(enter_mask),
		.set_index(set_index),
		.used_count(used_count)
	);

	age_matrix age_matrix_i (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.enter_mask(enter_mask),
		.after_matrix(after_matrix)
	);

endmodule

`default_nettype wire

// File: verilog/slot_allocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "scheduler_config.svh"

module slot_allocator
	import scheduler_pkg::*;
(
	input wire slot_mask_t free_mask,
	input wire issue_count_t count_lo,
	input wire issue_count_t count_hi,
	output slot_mask_t enter_mask,
	output set_index_t set_index [0:`SCHED_SLOT_COUNT-1],
	output issue_count_t used_count
);

	localparam int GROUP_COUNT = `SCHED_SLOT_COUNT / `SCHED_GROUP_SIZE;

	// *******************************************************************
	// lowest free slot selection
	// *******************************************************************

	// each group is walked from its lowest slot upward. The first free
	// slots, as many as the group was granted, are marked as entering.
	// ranks in the high group continue after those of the low group, so
	// the set indexes of one cycle form a dense range starting at zero.
	always_comb begin
		issue_count_t left;
		issue_count_t base;
		issue_count_t rank;
		int slot;
		enter_mask = '0;
		for (int s = 0; s < `SCHED_SLOT_COUNT; s++) begin
			set_index[s] = '0;
		end
		for (int g = 0; g < GROUP_COUNT; g++) begin
			// group 0 is the low group, every other group is the high one.
			left = (g == 0) ? count_lo : count_hi;
			base = (g == 0) ? issue_count_t'(0) : count_lo;
			rank = '0;
			for (int k = 0; k < `SCHED_GROUP_SIZE; k++) begin
				slot = g * `SCHED_GROUP_SIZE + k;
				if (rank != left && free_mask[slot]) begin
					enter_mask[slot] = 1'b1;
					set_index[slot] = base + rank;
					rank = rank + issue_count_t'(1);
				end
			end
		end
	end

	// every granted instruction finds a slot, since the planner never
	// grants a group more than it has free.
	assign used_count = count_lo + count_hi;

	// the planner's grant must line up with the free slots it registered.
	always_comb begin
		a_enter_matches_used: assert #0 ($countones(enter_mask) == int'(used_count));
	end

endmodule

`default_nettype wire
